// File: hw/instr_realign.sv
`timescale 1ns/10ps

module instr_realign (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 branch_i,
  input  prefetch_pkg::addr_t  branch_addr_i,

  // fetch stage
  input  logic                 ready_i,
  output logic                 valid_o,
  output prefetch_pkg::instr_t rdata_o,
  output prefetch_pkg::addr_t  addr_o,

  // line fetcher
  input  logic                 line_valid_i,
  input  prefetch_pkg::line_t  line_data_i,
  output logic                 line_req_o,
  output prefetch_pkg::addr_t  next_line_addr_o,
  output logic                 line_taken_o
);

  import prefetch_pkg::*;

  addr_t ptr_q;        // address of the instruction on offer
  addr_t ptr_next;
  line_t cur_line_q;
  logic  cur_valid_q;
  logic  cross_q;      // upper half saved, cur_line_q is already the next line
  half_t save_q;

  line_t line_shift;
  half_t half_sel;
  logic  is_full;
  logic  at_last_half;
  logic  crossword;
  logic  handshake;
  logic  leave_line;

  ////////////////////////////////////////
  // decode at the pointer
  ////////////////////////////////////////

  // halfword at the pointer ends up in the low bits, its successor above it
  assign line_shift = cur_line_q >> {ptr_q[LINE_OFFS_W-1:1], 4'b0000};
  assign half_sel   = line_shift[HALF_W-1:0];

  assign at_last_half = (ptr_q[LINE_OFFS_W-1:1] == (LINE_OFFS_W-1)'(HALFS_PER_LINE - 1));

  // a joined crossword is always a full instruction
  assign is_full = cross_q | (half_sel[1:0] == COMPRESSED_MASK);

  // full instruction in the last halfword needs the next line
  assign crossword = cur_valid_q & ~cross_q & at_last_half & is_full;

  ////////////////////////////////////////
  // fetch stage side
  ////////////////////////////////////////

  assign valid_o   = cur_valid_q & ~crossword & ~branch_i;
  assign handshake = valid_o & ready_i;

  assign rdata_o = cross_q ? {cur_line_q[HALF_W-1:0], save_q}
                           : line_shift[INSTR_W-1:0];
  assign addr_o  = ptr_q;

  assign ptr_next = ptr_q + (is_full ? addr_t'(4) : addr_t'(2));

  // consumed instruction moves the pointer out of the current line
  assign leave_line = handshake & ~cross_q &
                      (ptr_next[ADDR_W-1:LINE_OFFS_W] != ptr_q[ADDR_W-1:LINE_OFFS_W]);

  ////////////////////////////////////////
  // fetcher side
  ////////////////////////////////////////

  // promote the held line when empty, when leaving the line, or for a crossword
  assign line_taken_o = line_valid_i & ~branch_i &
                        (~cur_valid_q | leave_line | crossword);

  // pointer in the last word and nothing prefetched yet
  assign line_req_o = cur_valid_q & ~cross_q & ~line_valid_i &
                      (ptr_q[LINE_OFFS_W-1:2] == '1);

  assign next_line_addr_o = {ptr_q[ADDR_W-1:LINE_OFFS_W] + 1'b1, {LINE_OFFS_W{1'b0}}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q       <= '0;
      cur_valid_q <= 1'b0;
      cross_q     <= 1'b0;
    end else if (branch_i) begin
      ptr_q       <= branch_addr_i;
      cur_valid_q <= 1'b0;  // line of the old path is useless
      cross_q     <= 1'b0;
    end else begin
      if (handshake) begin
        ptr_q <= ptr_next;
      end

      if (line_taken_o) begin
        cur_valid_q <= 1'b1;
      end else if (leave_line || crossword) begin
        cur_valid_q <= 1'b0;  // wait for the line still in flight
      end

      if (crossword) begin
        cross_q <= 1'b1;
      end else if (handshake) begin
        cross_q <= 1'b0;  // joined word consumed, pointer now in the new line
      end
    end
  end

  always_ff @(posedge clk) begin
    if (line_taken_o) begin
      cur_line_q <= line_data_i;
    end
    if (crossword) begin
      save_q <= half_sel;  // lower half of the crossword
    end
  end

endmodule

// File: hw/l0_line_fetch.sv
`timescale 1ns/10ps

module l0_line_fetch (
  input  logic                clk,
  input  logic                rst_n,

  // redirect from the fetch stage
  input  logic                branch_i,
  input  prefetch_pkg::addr_t branch_addr_i,

  // from the realigner
  input  logic                line_req_i,
  input  prefetch_pkg::addr_t next_line_addr_i,
  input  logic                line_taken_i,

  // instruction memory
  output logic                instr_req_o,
  output prefetch_pkg::addr_t instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  prefetch_pkg::line_t instr_rdata_i,

  // held line toward the realigner
  output logic                line_valid_o,
  output prefetch_pkg::line_t line_data_o,

  output logic                busy_o
);

  import prefetch_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WAIT_GNT,
    S_WAIT_RVALID,
    S_ABORTED,
    S_HOLD
  } fetch_state_e;

  fetch_state_e state_q, state_n;
  addr_t        addr_q;    // line of the pending or outstanding request
  addr_t        req_addr;
  logic         issue;     // put a request on the bus this cycle
  logic         load;      // capture the returned line
  line_t        line_q;

  // a branch target always wins over the sequential line
  always_comb begin
    if (branch_i) begin
      req_addr = branch_addr_i;
    end else if (state_q == S_IDLE) begin
      req_addr = next_line_addr_i;
    end else begin
      req_addr = addr_q;
    end
  end

  ////////////////////////////////////////
  // request FSM
  ////////////////////////////////////////

  always_comb begin
    state_n = state_q;
    issue   = 1'b0;
    load    = 1'b0;

    case (state_q)
      S_IDLE: begin
        issue = branch_i | line_req_i;
      end
      S_WAIT_GNT: begin
        issue = 1'b1;  // keep asking until granted
      end
      S_WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          load    = ~branch_i;  // a line arriving with the branch is already stale
          issue   = branch_i;
          state_n = S_HOLD;
        end else if (branch_i) begin
          state_n = S_ABORTED;
        end
      end
      S_ABORTED: begin
        // old response still in flight, drop it and only then go for the target
        issue = instr_rvalid_i;
      end
      S_HOLD: begin
        issue = branch_i;
        if (line_taken_i) begin
          state_n = S_IDLE;
        end
      end
      default: begin
        state_n = S_IDLE;
      end
    endcase

    if (issue) begin
      state_n = instr_gnt_i ? S_WAIT_RVALID : S_WAIT_GNT;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_n;
      if (issue || branch_i) begin
        addr_q <= req_addr;  // also remembers a target seen while aborted
      end
    end
  end

  // one-line response buffer
  always_ff @(posedge clk) begin
    if (load) begin
      line_q <= instr_rdata_i;
    end
  end

  assign instr_req_o  = issue;
  assign instr_addr_o = {req_addr[ADDR_W-1:LINE_OFFS_W], {LINE_OFFS_W{1'b0}}};

  assign line_valid_o = (state_q == S_HOLD);
  assign line_data_o  = line_q;

  assign busy_o = issue | (state_q == S_WAIT_RVALID) | (state_q == S_ABORTED);

endmodule

// File: hw/prefetch_l0_top.sv
`timescale 1ns/10ps

module prefetch_l0_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // fetch stage
  input  logic                 branch_i,
  input  prefetch_pkg::addr_t  branch_addr_i,
  input  logic                 ready_i,
  output logic                 valid_o,
  output prefetch_pkg::instr_t rdata_o,
  output prefetch_pkg::addr_t  addr_o,

  // instruction memory
  output logic                 instr_req_o,
  output prefetch_pkg::addr_t  instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  prefetch_pkg::line_t  instr_rdata_i,

  output logic                 busy_o
);

  import prefetch_pkg::*;

  logic  line_req;        // next sequential line wanted
  addr_t next_line_addr;
  logic  line_taken;      // held line promoted to current
  logic  line_valid;
  line_t line_data;

  l0_line_fetch i_l0_line_fetch (
    .clk              (clk),
    .rst_n            (rst_n),
    .branch_i         (branch_i),
    .branch_addr_i    (branch_addr_i),
    .line_req_i       (line_req),
    .next_line_addr_i (next_line_addr),
    .line_taken_i     (line_taken),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .instr_gnt_i      (instr_gnt_i),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_rdata_i    (instr_rdata_i),
    .line_valid_o     (line_valid),
    .line_data_o      (line_data),
    .busy_o           (busy_o)
  );

  instr_realign i_instr_realign (
    .clk              (clk),
    .rst_n            (rst_n),
    .branch_i         (branch_i),
    .branch_addr_i    (branch_addr_i),
    .ready_i          (ready_i),
    .valid_o          (valid_o),
    .rdata_o          (rdata_o),
    .addr_o           (addr_o),
    .line_valid_i     (line_valid),
    .line_data_i      (line_data),
    .line_req_o       (line_req),
    .next_line_addr_o (next_line_addr),
    .line_taken_o     (line_taken)
  );

endmodule

// File: hw/prefetch_pkg.sv
package prefetch_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int ADDR_W  = 32;   // byte address
  localparam int LINE_W  = 128;  // one memory line
  localparam int INSTR_W = 32;   // word handed to the fetch stage
  localparam int HALF_W  = 16;   // compressed instruction size

  ////////////////////////////////////////
  // line geometry
  ////////////////////////////////////////

  localparam int LINE_OFFS_W    = 4;                // byte offset inside a line
  localparam int HALFS_PER_LINE = LINE_W / HALF_W;  // 8 halfwords

  // low two bits of a full instruction, anything else is compressed
  localparam logic [1:0] COMPRESSED_MASK = 2'b11;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [LINE_W-1:0]  line_t;
  typedef logic [INSTR_W-1:0] instr_t;
  typedef logic [HALF_W-1:0]  half_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the prefetch buffer testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_prefetch_l0 \
  -f tb.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "build or run failed"; exit 1; }
cat sim.log
grep -q "TEST RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tb.f
+incdir+include
hw/prefetch_pkg.sv
hw/l0_line_fetch.sv
hw/instr_realign.sv
hw/prefetch_l0_top.sv
verif/tb_prefetch_l0.sv

// File: include/tb_prefetch_ref.svh
`ifndef TB_PREFETCH_REF_SVH
`define TB_PREFETCH_REF_SVH

////////////////////////////////////////
// memory image
////////////////////////////////////////

// every halfword is a fixed hash of its address
// below 'h4000 the image holds only full instructions on word boundaries
function automatic prefetch_pkg::half_t mem_half(input prefetch_pkg::addr_t a);
  logic [31:0] h;
  h = (a ^ 32'h3c6e_f372) * 32'h9e37_79b1;
  h = h ^ (h >> 13);
  if ((a < 32'h0000_4000) && (a[1] == 1'b0)) begin
    return {h[31:18], prefetch_pkg::COMPRESSED_MASK};
  end
  return h[31:16];
endfunction

// whole line as the memory returns it, halfword 0 in the low bits
function automatic prefetch_pkg::line_t mem_line(input prefetch_pkg::addr_t a);
  prefetch_pkg::line_t l;
  prefetch_pkg::addr_t base;
  base = {a[31:prefetch_pkg::LINE_OFFS_W], {prefetch_pkg::LINE_OFFS_W{1'b0}}};
  for (int i = 0; i < prefetch_pkg::HALFS_PER_LINE; i++) begin
    l[i*prefetch_pkg::HALF_W +: prefetch_pkg::HALF_W] =
      mem_half(base + prefetch_pkg::addr_t'(2 * i));
  end
  return l;
endfunction

////////////////////////////////////////
// reference instruction stream
////////////////////////////////////////

function automatic bit ref_is_full(input prefetch_pkg::addr_t pc);
  prefetch_pkg::half_t h;
  h = mem_half(pc);
  return (h[1:0] == prefetch_pkg::COMPRESSED_MASK);
endfunction

// expected word, upper half zero for a compressed one
function automatic prefetch_pkg::instr_t ref_instr(input prefetch_pkg::addr_t pc);
  if (ref_is_full(pc)) begin
    return {mem_half(pc + 32'd2), mem_half(pc)};
  end
  return {16'h0000, mem_half(pc)};
endfunction

function automatic prefetch_pkg::addr_t ref_next(input prefetch_pkg::addr_t pc);
  return ref_is_full(pc) ? pc + 32'd4 : pc + 32'd2;
endfunction

// compressed instructions compare on the low halfword only
function automatic bit ref_match(input prefetch_pkg::addr_t pc,
                                 input prefetch_pkg::instr_t got);
  prefetch_pkg::instr_t exp;
  exp = ref_instr(pc);
  if (ref_is_full(pc)) begin
    return (got == exp);
  end
  return (got[15:0] == exp[15:0]);
endfunction

`endif

// File: verif/tb_prefetch_l0.sv
`timescale 1ns/10ps

module tb_prefetch_l0;

  import prefetch_pkg::*;

  `include "tb_prefetch_ref.svh"

  localparam int CLK_PERIOD   = 10;
  localparam int N_SEQ        = 64;
  localparam int N_MIX        = 200;
  localparam int N_BP         = 200;
  localparam int N_BR         = 200;
  localparam int WATCH_CYCLES = (N_SEQ + N_MIX + N_BP + N_BR) * 20 + 40;

  logic   clk;
  logic   rst_n;
  logic   branch_i;
  addr_t  branch_addr_i;
  logic   ready_i;
  logic   valid_o;
  instr_t rdata_o;
  addr_t  addr_o;
  logic   instr_req_o;
  addr_t  instr_addr_o;
  logic   instr_gnt_i;
  logic   instr_rvalid_i;
  line_t  instr_rdata_i;
  logic   busy_o;

  int unsigned consumed    = 0;  // instructions checked against the reference
  int unsigned errors      = 0;
  int unsigned prot_errors = 0;
  int unsigned requests    = 0;
  logic        outstanding = 1'b0;  // granted line without its response yet

  prefetch_l0_top i_prefetch_l0_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .rdata_o        (rdata_o),
    .addr_o         (addr_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  initial begin
    int unsigned rsp_wait;
    addr_t       rsp_addr;
    rsp_wait       = 0;
    rsp_addr       = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    forever begin
      @(posedge clk);
      if (instr_rvalid_i) begin
        outstanding = 1'b0;
      end
      if (instr_req_o) begin
        assert (instr_addr_o[LINE_OFFS_W-1:0] == '0) else begin
          errors++;
          prot_errors++;
          $display("error %0t: request address %h not line aligned", $time, instr_addr_o);
        end
      end
      if (instr_req_o && instr_gnt_i) begin
        requests++;
        assert (!outstanding) else begin
          errors++;
          prot_errors++;
          $display("error %0t: second grant before the outstanding response", $time);
        end
        outstanding = 1'b1;
        rsp_addr    = instr_addr_o;
        rsp_wait    = $urandom_range(2, 0);  // response 1 to 3 cycles after the grant
      end else if (outstanding && rsp_wait > 0) begin
        rsp_wait--;
      end
      #1;
      instr_rvalid_i = outstanding && (rsp_wait == 0);
      instr_rdata_i  = mem_line(rsp_addr);
      // memory accepts a request at random, busy or not
      instr_gnt_i    = ($urandom_range(3, 0) != 0);
    end
  end

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////

  initial begin
    addr_t  exp_pc;
    logic   stalled;
    addr_t  stall_addr;
    instr_t stall_data;
    exp_pc  = '0;
    stalled = 1'b0;
    forever begin
      @(posedge clk);
      if (branch_i) begin
        assert (!valid_o) else begin
          errors++;
          $display("error %0t: valid_o high in a branch cycle", $time);
        end
        exp_pc = branch_addr_i;  // old path ends here
      end
      if (stalled && !branch_i) begin
        assert (valid_o && addr_o == stall_addr && rdata_o == stall_data) else begin
          errors++;
          $display("error %0t: output moved under back-pressure, addr %h data %h",
                   $time, addr_o, rdata_o);
        end
      end
      if (valid_o && ready_i) begin
        assert (addr_o == exp_pc && ref_match(exp_pc, rdata_o)) else begin
          errors++;
          $display("error %0t: got addr %h data %h, expected addr %h data %h",
                   $time, addr_o, rdata_o, exp_pc, ref_instr(exp_pc));
        end
        exp_pc = ref_next(exp_pc);
        consumed++;
      end
      stalled    = valid_o && !ready_i && !branch_i;
      stall_addr = addr_o;
      stall_data = rdata_o;
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic redirect_to(input addr_t target);
    @(posedge clk);
    #1;
    branch_i      = 1'b1;
    branch_addr_i = target;
  endtask

  task automatic check_idle_after_reset();
    int unsigned err0;
    err0 = errors;
    repeat (10) begin
      @(posedge clk);
      assert (!valid_o && !instr_req_o && !busy_o) else begin
        errors++;
        $display("error %0t: activity before the first branch", $time);
      end
    end
    $display("test after_reset: 10 idle cycles, %0d errors", errors - err0);
  endtask

  task automatic stream_test(input string name, input addr_t start, input int unsigned n,
                             input int unsigned stall_pct, input bit random_branch);
    int unsigned err0;
    int unsigned target;
    int unsigned branches;
    int unsigned late;
    err0     = errors;
    target   = consumed + n;
    branches = 0;
    late     = 0;
    redirect_to(start);
    while (consumed < target) begin
      @(posedge clk);
      #1;
      branch_i = 1'b0;
      ready_i  = ($urandom_range(99, 0) >= stall_pct);
      if (random_branch && ($urandom_range(24, 0) == 0)) begin
        if (outstanding) begin
          late++;  // redirect with a line still in flight
        end
        branch_i      = 1'b1;
        branch_addr_i = 32'h0000_8000 | ($urandom() & 32'h0000_7ffe);
        branches++;
      end
    end
    @(posedge clk);
    #1;
    branch_i = 1'b0;
    ready_i  = 1'b0;
    $display("test %s: %0d instructions, %0d branches (%0d in flight), %0d errors",
             name, n, branches, late, errors - err0);
  endtask

  initial begin
    void'($urandom(32'ha780));
    rst_n         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    ready_i       = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_idle_after_reset();
    stream_test("sequential", 32'h0000_0100, N_SEQ, 0, 1'b0);
    stream_test("mixed", 32'h0000_8002, N_MIX, 0, 1'b0);
    stream_test("backpressure", 32'h0000_9006, N_BP, 50, 1'b0);
    stream_test("branch", 32'h0000_a00a, N_BR, 25, 1'b1);
    $display("test protocol: %0d requests, %0d errors", requests, prot_errors);
    $display("tests 6, instructions %0d, errors %0d", consumed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog, sized for every expected instruction at 20 cycles each
  initial begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("timeout: the prefetch buffer stopped delivering instructions");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
